//--- Bender.yml
package:
  name: game_view

sources:
  - rtl/game_view_pkg.sv
  - rtl/rect_painter.sv
  - rtl/object_table.sv
  - rtl/score_keeper.sv
  - rtl/level_timer.sv
  - rtl/view_sequencer.sv
  - rtl/game_view.sv
  - target: test
    files:
      - test/tb_game_view.sv

//--- filelist.f
rtl/game_view_pkg.sv
rtl/rect_painter.sv
rtl/object_table.sv
rtl/score_keeper.sv
rtl/level_timer.sv
rtl/view_sequencer.sv
rtl/game_view.sv
test/tb_game_view.sv

//--- rtl/game_view.sv
// game view top level
// connects the sequencer, painter, object table, score and timer
`timescale 1ns/1ns

module game_view
	import game_view_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       go,
	input  logic       obj_wr,
	input  obj_index_t obj_index,
	input  object_t    obj_data,
	input  logic       collect,
	input  obj_index_t collect_index,
	input  y_t         hook_len,
	output pixel_t     pixel,
	output score_t     score,
	output frames_t    time_remain
);
	obj_index_t obj_sel;
	object_t obj;
	rect_t paint_rect;
	gain_t gain;
	logic paint_start;
	logic paint_done;
	logic new_level;
	logic frame_tick;
	logic goal_met;
	logic time_up;

	view_sequencer u_sequencer (
		.clk(clk),
		.resetn(resetn),
		.go(go),
		.hook_len(hook_len),
		.obj(obj),
		.goal_met(goal_met),
		.time_up(time_up),
		.paint_done(paint_done),
		.obj_sel(obj_sel),
		.paint_start(paint_start),
		.paint_rect(paint_rect),
		.new_level(new_level),
		.frame_tick(frame_tick)
	);

	rect_painter u_painter (
		.clk(clk),
		.resetn(resetn),
		.start(paint_start),
		.rect(paint_rect),
		.pixel(pixel),
		.done(paint_done)
	);

	object_table u_objects (
		.clk(clk),
		.resetn(resetn),
		.obj_wr(obj_wr),
		.obj_index(obj_index),
		.obj_data(obj_data),
		.collect(collect),
		.collect_index(collect_index),
		.new_level(new_level),
		.obj_sel(obj_sel),
		.obj(obj),
		.gain(gain)
	);

	score_keeper u_score (
		.clk(clk),
		.resetn(resetn),
		.gain(gain),
		.new_level(new_level),
		.score(score),
		.goal_met(goal_met)
	);

	level_timer u_timer (
		.clk(clk),
		.resetn(resetn),
		.new_level(new_level),
		.frame_tick(frame_tick),
		.time_remain(time_remain),
		.time_up(time_up)
	);

endmodule

//--- rtl/game_view_pkg.sv
// game view shared definitions
// screen geometry, object counts, palette, score values and the common types
package game_view_pkg;

	typedef logic [8:0] x_t;
	typedef logic [7:0] y_t;
	typedef logic [11:0] color_t;
	typedef logic [3:0] obj_index_t;
	typedef logic [9:0] score_t;
	typedef logic [3:0] frames_t;

	localparam x_t SCREEN_W = 9'd320;
	localparam y_t SCREEN_H = 8'd240;
	localparam int OBJ_SIZE = 16;

	localparam int NUM_GOLD = 5;
	localparam int NUM_STONE = 7;
	localparam int NUM_DIAMOND = 3;
	localparam int NUM_OBJ = NUM_GOLD + NUM_STONE + NUM_DIAMOND;

	// hook hangs from the middle of the top edge
	localparam x_t HOOK_X = 9'd160;
	localparam x_t HOOK_W = 9'd2;

	localparam score_t GOAL = 10'd50;
	localparam frames_t LEVEL_FRAMES = 4'd6;
	localparam score_t VALUE_GOLD = 10'd10;
	localparam score_t VALUE_STONE = 10'd2;
	localparam score_t VALUE_DIAMOND = 10'd25;

	// palette, no entry is zero
	localparam color_t COLOR_BG = 12'h631;
	localparam color_t COLOR_GOLD = 12'hfc0;
	localparam color_t COLOR_STONE = 12'h888;
	localparam color_t COLOR_DIAMOND = 12'h0ef;
	localparam color_t COLOR_HOOK = 12'h222;
	localparam color_t COLOR_START = 12'h14a;
	localparam color_t COLOR_OVER = 12'ha11;
	localparam color_t COLOR_LEVEL = 12'h2a3;

	typedef enum logic [1:0] {
		kind_gold,
		kind_stone,
		kind_diamond
	} obj_kind_t;

	typedef enum logic [3:0] {
		start_paint,
		start_wait,
		bg_paint,
		obj_check,
		obj_paint,
		hook_paint,
		frame_end,
		level_paint,
		over_paint,
		end_wait
	} view_state_t;

	typedef struct packed {
		x_t x;
		y_t y;
		color_t color;
		logic write;
	} pixel_t;

	typedef struct packed {
		x_t x;
		y_t y;
		x_t width;
		y_t height;
		color_t color;
	} rect_t;

	typedef struct packed {
		x_t x;
		y_t y;
		obj_kind_t kind;
		logic visible;
	} object_t;

	typedef struct packed {
		logic valid;
		obj_kind_t kind;
	} gain_t;

endpackage

//--- rtl/level_timer.sv
// level timer
// counts down the frames left in the current level
`timescale 1ns/1ns

module level_timer
	import game_view_pkg::*;
(
	input  logic    clk,
	input  logic    resetn,
	input  logic    new_level,
	input  logic    frame_tick,
	output frames_t time_remain,
	output logic    time_up
);
	logic expired;

	assign expired = (time_remain == '0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			time_remain <= LEVEL_FRAMES;
		end else if (new_level) begin
			time_remain <= LEVEL_FRAMES;
		end else if (frame_tick && !expired) begin
			// holds at zero once the level has run out
			time_remain <= time_remain - frames_t'(1);
		end
	end

	assign time_up = expired;

endmodule

//--- rtl/object_table.sv
// treasure object table
// holds position and kind per object, tracks visibility and reports collections
`timescale 1ns/1ns

module object_table
	import game_view_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       obj_wr,
	input  obj_index_t obj_index,
	input  object_t    obj_data,
	input  logic       collect,
	input  obj_index_t collect_index,
	input  logic       new_level,
	input  obj_index_t obj_sel,
	output object_t    obj,
	output gain_t      gain
);
	x_t obj_x [NUM_OBJ];
	y_t obj_y [NUM_OBJ];
	obj_kind_t obj_kind [NUM_OBJ];
	logic [NUM_OBJ-1:0] written;
	logic [NUM_OBJ-1:0] visible;
	logic wr_ok;
	logic hit;
	logic gain_valid;
	obj_kind_t gain_kind;

	assign wr_ok = obj_wr && (obj_index < NUM_OBJ);
	// only a visible entry can be collected
	assign hit = collect && (collect_index < NUM_OBJ) && visible[collect_index];

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			obj_x[obj_index] <= obj_data.x;
			obj_y[obj_index] <= obj_data.y;
			obj_kind[obj_index] <= obj_data.kind;
		end
		gain_kind <= obj_kind[collect_index];
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			written <= '0;
			visible <= '0;
			gain_valid <= 1'b0;
		end else begin
			gain_valid <= hit;
			if (new_level)
				visible <= written;
			if (hit)
				visible[collect_index] <= 1'b0;
			// a write always shows the entry, whatever obj_data.visible says
			if (wr_ok) begin
				written[obj_index] <= 1'b1;
				visible[obj_index] <= 1'b1;
			end
		end
	end

	assign obj = '{
		x: obj_x[obj_sel],
		y: obj_y[obj_sel],
		kind: obj_kind[obj_sel],
		visible: visible[obj_sel]
	};
	assign gain = '{valid: gain_valid, kind: gain_kind};

endmodule

//--- rtl/rect_painter.sv
// rectangle painter
// walks a solid rectangle row by row, one registered pixel per cycle
`timescale 1ns/1ns

module rect_painter
	import game_view_pkg::*;
(
	input  logic   clk,
	input  logic   resetn,
	input  logic   start,
	input  rect_t  rect,
	output pixel_t pixel,
	output logic   done
);
	x_t cur_x;
	y_t cur_y;
	x_t cur_w;
	y_t cur_h;
	x_t col;
	y_t row;
	x_t col_nx;
	y_t row_nx;
	x_t pix_x;
	y_t pix_y;
	color_t pix_color;
	logic pix_write;
	logic busy;
	logic launch;
	logic wrap;
	logic last_nx;
	logic last_first;

	assign launch = start && !busy;
	// a 1x1 rectangle is finished with its first pixel
	assign last_first = (rect.width == x_t'(1)) && (rect.height == y_t'(1));

	always_comb begin
		wrap = (col == cur_w - x_t'(1));
		col_nx = wrap ? '0 : col + x_t'(1);
		row_nx = wrap ? row + y_t'(1) : row;
		last_nx = (col_nx == cur_w - x_t'(1)) && (row_nx == cur_h - y_t'(1));
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			done <= 1'b0;
			pix_write <= 1'b0;
		end else if (launch) begin
			busy <= !last_first;
			done <= last_first;
			pix_write <= 1'b1;
		end else if (busy) begin
			busy <= !last_nx;
			done <= last_nx;
			pix_write <= 1'b1;
		end else begin
			done <= 1'b0;
			pix_write <= 1'b0;
		end
	end

	// position counters and pixel payload
	always_ff @(posedge clk) begin
		if (launch) begin
			cur_x <= rect.x;
			cur_y <= rect.y;
			cur_w <= rect.width;
			cur_h <= rect.height;
			col <= '0;
			row <= '0;
			pix_x <= rect.x;
			pix_y <= rect.y;
			pix_color <= rect.color;
		end else if (busy) begin
			col <= col_nx;
			row <= row_nx;
			pix_x <= cur_x + col_nx;
			pix_y <= cur_y + row_nx;
		end
	end

	assign pixel = '{x: pix_x, y: pix_y, color: pix_color, write: pix_write};

endmodule

//--- rtl/score_keeper.sv
// score accumulator
// adds the value of each collected kind and flags when the level goal is met
`timescale 1ns/1ns

module score_keeper
	import game_view_pkg::*;
(
	input  logic   clk,
	input  logic   resetn,
	input  gain_t  gain,
	input  logic   new_level,
	output score_t score,
	output logic   goal_met
);
	score_t value;
	score_t score_nx;
	logic [10:0] sum;

	always_comb begin
		case (gain.kind)
			kind_gold: value = VALUE_GOLD;
			kind_stone: value = VALUE_STONE;
			kind_diamond: value = VALUE_DIAMOND;
			default: value = '0;
		endcase
		sum = {1'b0, score} + {1'b0, value};
		if (new_level)
			score_nx = '0;
		else if (gain.valid)
			score_nx = sum[10] ? '1 : sum[9:0];
		else
			score_nx = score;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			score <= '0;
			goal_met <= 1'b0;
		end else begin
			score <= score_nx;
			// compare the new score so the flag tracks it without lag
			goal_met <= (score_nx >= GOAL);
		end
	end

endmodule

//--- rtl/view_sequencer.sv
// view sequencer
// FSM that orders the start, frame, level and game-over screens
// and hands each layer to the painter as one rectangle
`timescale 1ns/1ns

module view_sequencer
	import game_view_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       go,
	input  y_t         hook_len,
	input  object_t    obj,
	input  logic       goal_met,
	input  logic       time_up,
	input  logic       paint_done,
	output obj_index_t obj_sel,
	output logic       paint_start,
	output rect_t      paint_rect,
	output logic       new_level,
	output logic       frame_tick
);
	view_state_t state;
	view_state_t state_nx;
	view_state_t after_objs;
	obj_index_t sel_nx;
	logic issued;
	logic paint_state;
	logic last_obj;

	function automatic color_t kind_color(input obj_kind_t kind);
		case (kind)
			kind_gold: return COLOR_GOLD;
			kind_diamond: return COLOR_DIAMOND;
			default: return COLOR_STONE;
		endcase
	endfunction

	assign last_obj = (obj_sel == obj_index_t'(NUM_OBJ - 1));
	// no hook layer when the rope has no length
	assign after_objs = (hook_len == '0) ? frame_end : hook_paint;

	always_comb begin
		state_nx = state;
		sel_nx = obj_sel;
		new_level = 1'b0;
		case (state)
			start_paint: begin
				if (paint_done)
					state_nx = start_wait;
			end
			start_wait: begin
				if (go)
					state_nx = bg_paint;
			end
			bg_paint: begin
				if (paint_done) begin
					state_nx = obj_check;
					sel_nx = '0;
				end
			end
			obj_check: begin
				if (obj.visible)
					state_nx = obj_paint;
				else if (last_obj)
					state_nx = after_objs;
				else
					sel_nx = obj_sel + obj_index_t'(1);
			end
			obj_paint: begin
				if (paint_done && last_obj) begin
					state_nx = after_objs;
				end else if (paint_done) begin
					state_nx = obj_check;
					sel_nx = obj_sel + obj_index_t'(1);
				end
			end
			hook_paint: begin
				if (paint_done)
					state_nx = frame_end;
			end
			frame_end: begin
				if (goal_met)
					state_nx = level_paint;
				else if (time_up)
					state_nx = over_paint;
				else
					state_nx = bg_paint;
			end
			level_paint, over_paint: begin
				if (paint_done)
					state_nx = end_wait;
			end
			end_wait: begin
				if (go) begin
					new_level = 1'b1;
					state_nx = bg_paint;
				end
			end
			default: state_nx = start_paint;
		endcase
	end

	// tick on the way into frame_end, so time_up there already counts this frame
	assign frame_tick = (state_nx == frame_end) && (state != frame_end);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= start_paint;
			obj_sel <= '0;
		end else begin
			state <= state_nx;
			obj_sel <= sel_nx;
		end
	end

	assign paint_state = state inside {start_paint, bg_paint, obj_paint,
		hook_paint, level_paint, over_paint};
	// one start per paint state, the painter answers with done
	assign paint_start = paint_state && !issued;

	always_ff @(posedge clk) begin
		if (!resetn)
			issued <= 1'b0;
		else if (paint_done)
			issued <= 1'b0;
		else if (paint_start)
			issued <= 1'b1;
	end

	always_comb begin
		paint_rect = '{x: '0, y: '0, width: SCREEN_W, height: SCREEN_H, color: COLOR_BG};
		case (state)
			start_paint: paint_rect.color = COLOR_START;
			level_paint: paint_rect.color = COLOR_LEVEL;
			over_paint: paint_rect.color = COLOR_OVER;
			obj_paint: begin
				paint_rect = '{x: obj.x, y: obj.y, width: x_t'(OBJ_SIZE),
					height: y_t'(OBJ_SIZE), color: kind_color(obj.kind)};
			end
			hook_paint: begin
				paint_rect = '{x: HOOK_X, y: '0, width: HOOK_W,
					height: hook_len, color: COLOR_HOOK};
			end
			default: ;
		endcase
	end

endmodule

//--- test/tb_game_view.sv
// game view testbench
// random objects, collects and hook lengths, every written pixel checked in order
`timescale 1ns/1ns

module tb_game_view
	import game_view_pkg::*;
();
	localparam int WAIT_LIMIT = 2000;

	logic clk;
	logic resetn;
	logic go;
	logic obj_wr;
	obj_index_t obj_index;
	object_t obj_data;
	logic collect;
	obj_index_t collect_index;
	y_t hook_len;
	pixel_t pixel;
	score_t score;
	frames_t time_remain;

	logic [31:0] lfsr;
	// model of the object table, score and timer
	int m_x [NUM_OBJ];
	int m_y [NUM_OBJ];
	obj_kind_t m_kind [NUM_OBJ];
	logic m_vis [NUM_OBJ];
	int m_score;
	int m_time;
	int next_pick;

	game_view DUT (
		.clk(clk),
		.resetn(resetn),
		.go(go),
		.obj_wr(obj_wr),
		.obj_index(obj_index),
		.obj_data(obj_data),
		.collect(collect),
		.collect_index(collect_index),
		.hook_len(hook_len),
		.pixel(pixel),
		.score(score),
		.time_remain(time_remain)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// galois LFSR stepped once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic color_t palette_of(input obj_kind_t kind);
		case (kind)
			kind_gold: return 12'hfc0;
			kind_stone: return 12'h888;
			default: return 12'h0ef;
		endcase
	endfunction

	function automatic int points_of(input obj_kind_t kind);
		case (kind)
			kind_gold: return 10;
			kind_stone: return 2;
			default: return 25;
		endcase
	endfunction

	// 5 gold, 7 stone, 3 diamond
	function automatic obj_kind_t set_kind(input int n);
		if (n < 5)
			return kind_gold;
		else if (n < 12)
			return kind_stone;
		return kind_diamond;
	endfunction

	task automatic stop_on_failure;
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic next_write;
		int waited;
		waited = 0;
		@(negedge clk);
		while (!pixel.write) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("no pixel was written for %0d cycles", WAIT_LIMIT);
				stop_on_failure();
			end
			@(negedge clk);
		end
	endtask

	task automatic check_rect(input int x0, input int y0, input int w, input int h,
		input color_t c);
		for (int row = 0; row < h; row++) begin
			for (int col = 0; col < w; col++) begin
				next_write();
				check("pixel {x,y,color}", {pixel.x, pixel.y, pixel.color},
					{x_t'(x0 + col), y_t'(y0 + row), c});
			end
		end
	endtask

	task automatic collected(input obj_index_t idx);
		if (idx < NUM_OBJ && m_vis[idx]) begin
			m_vis[idx] = 1'b0;
			m_score = m_score + points_of(m_kind[idx]);
			if (m_score > 1023)
				m_score = 1023;
		end
	endtask

	task automatic write_objects;
		int rot;
		logic vis_bit;
		rot = random_bits(4) % NUM_OBJ;
		for (int i = 0; i < NUM_OBJ; i++) begin
			m_x[i] = random_bits(9) % (SCREEN_W - OBJ_SIZE + 1);
			m_y[i] = random_bits(8) % (SCREEN_H - OBJ_SIZE + 1);
			m_kind[i] = set_kind((i + rot) % NUM_OBJ);
			m_vis[i] = 1'b1;
			// the table ignores this bit on a write
			vis_bit = random_bits(1) != 0;
			@(posedge clk);
			obj_wr <= 1'b1;
			obj_index <= obj_index_t'(i);
			obj_data <= '{x: x_t'(m_x[i]), y: y_t'(m_y[i]), kind: m_kind[i], visible: vis_bit};
		end
		@(posedge clk);
		obj_wr <= 1'b0;
	endtask

	task automatic press_go;
		repeat (random_bits(4)) @(posedge clk);
		@(posedge clk);
		go <= 1'b1;
	endtask

	// hook length and collects of one frame, driven during its background
	// mode 0 picks at random, mode 1 in index order, mode 2 collects nothing
	task automatic drive_frame(input int mode, input y_t hook);
		int count;
		obj_index_t idx;
		obj_index_t first;
		count = (mode == 2) ? 0 : ((mode == 1) ? 4 : 3);
		first = '0;
		@(posedge clk);
		go <= 1'b0;
		hook_len <= hook;
		for (int k = 0; k < count; k++) begin
			if (mode == 1) begin
				idx = obj_index_t'(next_pick);
				next_pick++;
			end else if (k == 1) begin
				// same object a second time
				idx = first;
			end else begin
				idx = obj_index_t'(random_bits(4));
			end
			if (k == 0)
				first = idx;
			repeat (random_bits(3)) @(posedge clk);
			@(posedge clk);
			collect <= 1'b1;
			collect_index <= idx;
			@(posedge clk);
			collect <= 1'b0;
			collected(idx);
		end
	endtask

	task automatic play_frame(input int mode, input int frame);
		y_t hook;
		if (mode == 2 && frame % 2 == 1)
			hook = '0;
		else
			hook = y_t'(random_bits(7));
		check_rect(0, 0, SCREEN_W, 1, COLOR_BG);
		check("score", score, m_score);
		check("time_remain", time_remain, m_time);
		fork
			check_rect(0, 1, SCREEN_W, SCREEN_H - 1, COLOR_BG);
			drive_frame(mode, hook);
		join
		for (int i = 0; i < NUM_OBJ; i++) begin
			if (m_vis[i])
				check_rect(m_x[i], m_y[i], OBJ_SIZE, OBJ_SIZE, palette_of(m_kind[i]));
		end
		if (hook != '0)
			check_rect(HOOK_X, 0, HOOK_W, hook, COLOR_HOOK);
	endtask

	task automatic play_level(input int mode);
		int frame;
		logic ended;
		logic won;
		frame = 0;
		ended = 1'b0;
		won = 1'b0;
		while (!ended) begin
			play_frame(mode, frame);
			frame++;
			if (m_time > 0)
				m_time--;
			// goal wins over a timeout in the same frame
			if (m_score >= 50) begin
				won = 1'b1;
				ended = 1'b1;
			end else if (m_time == 0) begin
				ended = 1'b1;
			end
		end
		check_rect(0, 0, SCREEN_W, SCREEN_H, won ? COLOR_LEVEL : COLOR_OVER);
		check("score", score, m_score);
		check("time_remain", time_remain, m_time);
	endtask

	task automatic next_level;
		for (int i = 0; i < NUM_OBJ; i++)
			m_vis[i] = 1'b1;
		m_score = 0;
		m_time = 6;
		next_pick = 0;
		press_go();
	endtask

	initial begin
		lfsr = 32'he2b5;
		resetn = 1'b0;
		go = 1'b0;
		obj_wr = 1'b0;
		obj_index = '0;
		obj_data = '0;
		collect = 1'b0;
		collect_index = '0;
		hook_len = '0;
		m_score = 0;
		m_time = 6;
		next_pick = 0;
		for (int i = 0; i < NUM_OBJ; i++)
			m_vis[i] = 1'b0;
		repeat (4) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check("pixel.write", pixel.write, 1'b0);
		check("score", score, 0);
		check("time_remain", time_remain, 6);
		check_rect(0, 0, SCREEN_W, SCREEN_H, COLOR_START);
		write_objects();
		press_go();
		play_level(0);
		// collect everything in order until the goal
		next_level();
		play_level(1);
		// no collects, so the timer runs out
		next_level();
		play_level(2);
		repeat (20) begin
			@(negedge clk);
			check("pixel.write", pixel.write, 1'b0);
		end
		$display("All tests passed");
		$finish;
	end

endmodule
